// File: cpuPkg.sv
package cpuPkg;

   // Width of the internal bus and of every register.
   // The instruction format is built around 8 bits.
   localparam int dataWidth = 8;

   // Destination field, instruction bits 6..4.
   typedef enum logic [2:0] {
      destNone = 3'd0,
      destPc   = 3'd1,
      destA    = 3'd2,
      destB    = 3'd3,
      destX    = 3'd4,
      destRam  = 3'd5,
      destQ    = 3'd6,
      destHalt = 3'd7
   } destT;

   // Source field, instruction bits 2..0.
   typedef enum logic [2:0] {
      srcRom  = 3'd0,
      srcZero = 3'd1,
      srcA    = 3'd2,
      srcB    = 3'd3,
      srcX    = 3'd4,
      srcRam  = 3'd5,
      srcE    = 3'd6,
      srcS    = 3'd7
   } srcT;

   // Sequencer phase.
   typedef enum logic [1:0] {
      phIdle    = 2'd0,
      phFetch   = 2'd1,
      phExecute = 2'd2,
      phHalt    = 2'd3
   } phaseT;

   // Jump condition, encoded as {bit7, bit3}.
   typedef enum logic [1:0] {
      condAlways = 2'b00,
      condZero   = 2'b01,
      condCarry  = 2'b10,
      condShift  = 2'b11
   } condT;

endpackage

// File: controlDecoder.sv
`timescale 1ns/100ps

module controlDecoder import cpuPkg::*; (
   input  logic [dataWidth-1:0] ir,
   input  logic                 execEn,
   input  logic                 aIsZero,
   input  logic                 flagCarry,
   input  logic                 flagShift,
   output logic                 loadA,
   output logic                 loadB,
   output logic                 loadX,
   output logic                 loadQ,
   output logic                 storeRam,
   output srcT                  srcSel,
   output logic                 doSubtract,
   output logic                 doCarryIn,
   output logic                 doShiftIn,
   output logic                 captureCarry,
   output logic                 captureShift,
   output logic                 pcInc,
   output logic                 doJump,
   output logic                 haltReq
);

   logic bit7;
   logic bit3;
   destT dest;
   condT cond;
   logic condMet;

   // Split the instruction byte into its fields.
   assign bit7   = ir[7];
   assign bit3   = ir[3];
   assign dest   = destT'(ir[6:4]);
   assign srcSel = srcT'(ir[2:0]);
   assign cond   = condT'({bit7, bit3});

   // Destination strobes, only live while executing.
   assign loadA    = execEn && (dest == destA);
   assign loadB    = execEn && (dest == destB);
   assign loadX    = execEn && (dest == destX);
   assign loadQ    = execEn && (dest == destQ);
   assign storeRam = execEn && (dest == destRam);
   assign haltReq  = execEn && (dest == destHalt);

   // The mode bits feed the ALU directly.
   assign doSubtract = bit3;
   assign doCarryIn  = bit7;
   assign doShiftIn  = bit3;

   // Flags follow whichever ALU result is put on the bus.
   assign captureCarry = execEn && (srcSel == srcE);
   assign captureShift = execEn && (srcSel == srcS);

   // An immediate operand is consumed from the ROM.
   assign pcInc = execEn && (srcSel == srcRom);

   always_comb begin
      condMet = 1'b0;
      case (cond)
         condAlways: condMet = 1'b1;
         condZero:   condMet = aIsZero;
         condCarry:  condMet = flagCarry;
         condShift:  condMet = flagShift;
         default:    condMet = 1'b0;
      endcase
   end

   assign doJump = execEn && (dest == destPc) && condMet;

endmodule

// File: phaseSequencer.sv
`timescale 1ns/100ps

module phaseSequencer import cpuPkg::*; (
   input  logic clk,
   input  logic arstN,
   input  logic start,
   input  logic haltReq,
   output logic fetchEn,
   output logic execEn,
   output logic halted
);

   phaseT state;
   phaseT stateNext;

   always_comb begin
      stateNext = state;
      case (state)
         phIdle: begin
            if (start) begin
               stateNext = phFetch;
            end
         end
         phFetch:   stateNext = phExecute;
         // A halt instruction parks the machine until reset.
         phExecute: stateNext = haltReq ? phHalt : phFetch;
         phHalt:    stateNext = phHalt;
         default:   stateNext = phIdle;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= phIdle;
      end else begin
         state <= stateNext;
      end
   end

   assign fetchEn = (state == phFetch);
   assign execEn  = (state == phExecute);
   assign halted  = (state == phHalt);

endmodule

// File: programCounter.sv
`timescale 1ns/100ps

module programCounter #(
   parameter int romAddrWidth = 8
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    fetchEn,
   input  logic                    pcInc,
   input  logic                    doJump,
   input  logic [romAddrWidth-1:0] jumpTarget,
   output logic [romAddrWidth-1:0] pc
);

   logic [romAddrWidth-1:0] pcPlusOne;

   assign pcPlusOne = pc + 1'b1;

   // A taken jump wins over the immediate increment.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (doJump) begin
         pc <= jumpTarget;
      end else if (fetchEn || pcInc) begin
         pc <= pcPlusOne;
      end
   end

   // Jumps only come from the execute phase.
   assert property (@(posedge clk) disable iff (!arstN) !(fetchEn && doJump))
      else $error("programCounter: jump during fetch");

   // Immediate increment and fetch increment never overlap.
   assert property (@(posedge clk) disable iff (!arstN) !(fetchEn && pcInc))
      else $error("programCounter: double increment");

endmodule

// File: registerFile.sv
`timescale 1ns/100ps

module registerFile import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic [dataWidth-1:0] bus,
   input  logic                 loadA,
   input  logic                 loadB,
   input  logic                 loadX,
   input  logic                 loadQ,
   output logic [dataWidth-1:0] regA,
   output logic [dataWidth-1:0] regB,
   output logic [dataWidth-1:0] regX,
   output logic [dataWidth-1:0] outValue,
   output logic                 outStrobe
);

   // Working registers.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regA <= '0;
         regB <= '0;
         regX <= '0;
      end else begin
         if (loadA) begin
            regA <= bus;
         end
         if (loadB) begin
            regB <= bus;
         end
         if (loadX) begin
            regX <= bus;
         end
      end
   end

   // Output register Q and its one-cycle strobe.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         outValue  <= '0;
         outStrobe <= 1'b0;
      end else begin
         outStrobe <= loadQ;
         if (loadQ) begin
            outValue <= bus;
         end
      end
   end

endmodule

// File: aluShifter.sv
`timescale 1ns/100ps

module aluShifter import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic [dataWidth-1:0] regA,
   input  logic [dataWidth-1:0] regB,
   input  logic                 doSubtract,
   input  logic                 doCarryIn,
   input  logic                 doShiftIn,
   input  logic                 captureCarry,
   input  logic                 captureShift,
   output logic [dataWidth-1:0] sumE,
   output logic [dataWidth-1:0] shiftS,
   output logic                 flagCarry,
   output logic                 flagShift,
   output logic                 aIsZero
);

   logic [dataWidth-1:0] operandB;
   logic [dataWidth:0]   sumFull;
   logic                 carryOut;

   // Subtraction is A plus the complement of B, carry-in from bit 7.
   assign operandB = doSubtract ? ~regB : regB;
   assign sumFull  = {1'b0, regA} + {1'b0, operandB} + {{dataWidth{1'b0}}, doCarryIn};
   assign sumE     = sumFull[dataWidth-1:0];
   assign carryOut = sumFull[dataWidth];

   // Left shift, new LSB from bit 3.
   assign shiftS = {regA[dataWidth-2:0], doShiftIn};

   assign aIsZero = (regA == '0);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         flagCarry <= 1'b0;
         flagShift <= 1'b0;
      end else begin
         if (captureCarry) begin
            flagCarry <= carryOut;
         end
         // The bit shifted out of A.
         if (captureShift) begin
            flagShift <= regA[dataWidth-1];
         end
      end
   end

   // Only one ALU result can be the bus source.
   assert property (@(posedge clk) disable iff (!arstN) !(captureCarry && captureShift))
      else $error("aluShifter: both flags captured at once");

endmodule

// File: programMemory.sv
`timescale 1ns/100ps

module programMemory import cpuPkg::*; #(
   parameter int romAddrWidth = 8,
   parameter int ramAddrWidth = 8
) (
   input  logic                    clk,
   input  logic                    progWe,
   input  logic [romAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   input  logic [romAddrWidth-1:0] pc,
   input  logic [ramAddrWidth-1:0] ramAddr,
   input  logic                    storeRam,
   input  logic [dataWidth-1:0]    bus,
   output logic [dataWidth-1:0]    romData,
   output logic [dataWidth-1:0]    ramData
);

   localparam int romDepth = 2 ** romAddrWidth;
   localparam int ramDepth = 2 ** ramAddrWidth;

   logic [dataWidth-1:0] romArray [romDepth];
   logic [dataWidth-1:0] ramArray [ramDepth];

   // Program store, written through the load port.
   always_ff @(posedge clk) begin
      if (progWe) begin
         romArray[progAddr] <= progData;
      end
   end

   // Data store, addressed by X.
   always_ff @(posedge clk) begin
      if (storeRam) begin
         ramArray[ramAddr] <= bus;
      end
   end

   // Asynchronous reads.
   assign romData = romArray[pc];
   assign ramData = ramArray[ramAddr];

endmodule

// File: cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; #(
   parameter int romAddrWidth = 8,
   parameter int ramAddrWidth = 8
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    start,
   input  logic                    progWe,
   input  logic [romAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   output logic [dataWidth-1:0]    outValue,
   output logic                    outStrobe,
   output logic                    halted
);

   logic                    fetchEn, execEn, haltReq;
   logic [dataWidth-1:0]    ir, bus;
   logic [dataWidth-1:0]    regA, regB, regX;
   logic [dataWidth-1:0]    sumE, shiftS, romData, ramData;
   logic                    loadA, loadB, loadX, loadQ, storeRam;
   logic                    doSubtract, doCarryIn, doShiftIn;
   logic                    captureCarry, captureShift;
   logic                    flagCarry, flagShift, aIsZero;
   logic                    pcInc, doJump;
   srcT                     srcSel;
   logic [romAddrWidth-1:0] pc;

   // Instruction register, loaded from the ROM during fetch.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ir <= '0;
      end else if (fetchEn) begin
         ir <= romData;
      end
   end

   // Internal bus.
   always_comb begin
      case (srcSel)
         srcRom:  bus = romData;
         srcZero: bus = '0;
         srcA:    bus = regA;
         srcB:    bus = regB;
         srcX:    bus = regX;
         srcRam:  bus = ramData;
         srcE:    bus = sumE;
         srcS:    bus = shiftS;
         default: bus = '0;
      endcase
   end

   phaseSequencer seq_i (.clk(clk), .arstN(arstN), .start(start), .haltReq(haltReq),
      .fetchEn(fetchEn), .execEn(execEn), .halted(halted));

   controlDecoder dec_i (.ir(ir), .execEn(execEn), .aIsZero(aIsZero),
      .flagCarry(flagCarry), .flagShift(flagShift), .loadA(loadA), .loadB(loadB),
      .loadX(loadX), .loadQ(loadQ), .storeRam(storeRam), .srcSel(srcSel),
      .doSubtract(doSubtract), .doCarryIn(doCarryIn), .doShiftIn(doShiftIn),
      .captureCarry(captureCarry), .captureShift(captureShift), .pcInc(pcInc),
      .doJump(doJump), .haltReq(haltReq));

   programCounter #(.romAddrWidth(romAddrWidth)) pc_i (.clk(clk), .arstN(arstN),
      .fetchEn(fetchEn), .pcInc(pcInc), .doJump(doJump),
      .jumpTarget(romAddrWidth'(bus)), .pc(pc));

   registerFile regs_i (.clk(clk), .arstN(arstN), .bus(bus), .loadA(loadA),
      .loadB(loadB), .loadX(loadX), .loadQ(loadQ), .regA(regA), .regB(regB),
      .regX(regX), .outValue(outValue), .outStrobe(outStrobe));

   aluShifter alu_i (.clk(clk), .arstN(arstN), .regA(regA), .regB(regB),
      .doSubtract(doSubtract), .doCarryIn(doCarryIn), .doShiftIn(doShiftIn),
      .captureCarry(captureCarry), .captureShift(captureShift), .sumE(sumE),
      .shiftS(shiftS), .flagCarry(flagCarry), .flagShift(flagShift), .aIsZero(aIsZero));

   programMemory #(.romAddrWidth(romAddrWidth), .ramAddrWidth(ramAddrWidth)) mem_i (
      .clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData), .pc(pc),
      .ramAddr(ramAddrWidth'(regX)), .storeRam(storeRam), .bus(bus),
      .romData(romData), .ramData(ramData));

endmodule

// File: tbChecker.sv
`timescale 1ns/100ps

module tbChecker import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 progWe,
   input  logic [7:0]           progAddr,
   input  logic [dataWidth-1:0] progData,
   input  logic                 start,
   input  logic [dataWidth-1:0] outValue,
   input  logic                 outStrobe,
   input  logic                 halted,
   output int                   errorCount,
   output int                   checkCount
);

   logic [7:0] romMirror [256];
   logic [7:0] expQ [256];
   int         expCount;
   int         outIdx;
   bit         expHalts;
   bit         programOpen;
   bit         haltSeen;

   // Copy of the program ROM, taken from the load port.
   always @(posedge clk) begin
      if (progWe) begin
         romMirror[progAddr] <= progData;
      end
   end

   // Instruction-level model of the CPU. Fills expQ and returns 1 if the program halts.
   function automatic bit runReference();
      logic [7:0] ram [256];
      logic [7:0] pc, a, b, x, ir, busValue, opB;
      logic [8:0] sum;
      logic       carry, shiftFlag, taken;
      int         n;
      pc = 8'h00;
      a = 8'h00;
      b = 8'h00;
      x = 8'h00;
      carry = 1'b0;
      shiftFlag = 1'b0;
      expCount = 0;
      for (n = 0; n < 256; n++) begin
         ir = romMirror[pc];
         pc = pc + 8'd1;
         opB = ir[3] ? ~b : b;
         sum = {1'b0, a} + {1'b0, opB} + {8'd0, ir[7]};
         case (srcT'(ir[2:0]))
            srcRom: begin
               busValue = romMirror[pc];
               pc = pc + 8'd1;
            end
            srcZero: busValue = 8'h00;
            srcA:    busValue = a;
            srcB:    busValue = b;
            srcX:    busValue = x;
            srcRam:  busValue = ram[x];
            srcE:    busValue = sum[7:0];
            default: busValue = {a[6:0], ir[3]};
         endcase
         // Condition sees the flags from before this instruction.
         case ({ir[7], ir[3]})
            2'b00:   taken = 1'b1;
            2'b01:   taken = (a == 8'h00);
            2'b10:   taken = carry;
            default: taken = shiftFlag;
         endcase
         if (srcT'(ir[2:0]) == srcE) begin
            carry = sum[8];
         end
         if (srcT'(ir[2:0]) == srcS) begin
            shiftFlag = a[7];
         end
         case (destT'(ir[6:4]))
            destPc: begin
               if (taken) begin
                  pc = busValue;
               end
            end
            destA:   a = busValue;
            destB:   b = busValue;
            destX:   x = busValue;
            destRam: ram[x] = busValue;
            destQ: begin
               expQ[8'(expCount)] = busValue;
               expCount++;
            end
            destHalt: return 1'b1;
            default: ;
         endcase
      end
      return 1'b0;
   endfunction

   always @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         if (programOpen && !haltSeen && expHalts) begin
            $display("Missing halt: the program was still running when reset came");
            errorCount++;
         end
         programOpen = 1'b0;
      end else begin
         if (start && !programOpen) begin
            expHalts = runReference();
            programOpen = 1'b1;
            haltSeen = 1'b0;
            outIdx = 0;
         end
         if (programOpen && outStrobe) begin
            if (outIdx >= expCount) begin
               $display("Surplus output: value 0x%02h after all %0d expected outputs",
                        outValue, expCount);
               errorCount++;
            end else if (outValue !== expQ[8'(outIdx)]) begin
               $display("ERROR outValue: expected 0x%02h, got 0x%02h (output %0d)",
                        expQ[8'(outIdx)], outValue, outIdx);
               errorCount++;
            end
            checkCount++;
            outIdx++;
         end
         if (programOpen && halted && !haltSeen) begin
            haltSeen = 1'b1;
            if (!expHalts) begin
               $display("Unexpected halt: the reference program does not halt");
               errorCount++;
            end else if (outIdx != expCount) begin
               $display("Early halt: only %0d of %0d outputs seen", outIdx, expCount);
               errorCount++;
            end
         end
      end
   end

endmodule

// File: tbCpu.sv
`timescale 1ns/100ps

module tbCpu import cpuPkg::*; ();

   localparam int romAddrWidth = 8;
   localparam int ramAddrWidth = 8;
   localparam int resetCycles  = 10;
   // One run is at most 256 instructions of two cycles, plus slack.
   localparam int runBudget    = 2 * 256 + 20;
   localparam int programCount = 8;
   // Every program also spends cycles in reset and ROM loading.
   localparam int timeoutLimit = programCount * (runBudget + resetCycles + 2 ** romAddrWidth + 4)
                                 + resetCycles + 10;
   localparam logic [15:0] lfsrSeed = 16'd25736;

   logic                    clk, arstN, start, progWe, outStrobe, halted;
   logic [romAddrWidth-1:0] progAddr;
   logic [dataWidth-1:0]    progData, outValue;
   logic [7:0]              progBytes [$];
   logic [15:0]             lfsrState;
   int                      errorCount, checkCount, cycleCount;

   cpuTop #(.romAddrWidth(romAddrWidth), .ramAddrWidth(ramAddrWidth)) dut_i (
      .clk(clk), .arstN(arstN), .start(start), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .outValue(outValue), .outStrobe(outStrobe), .halted(halted));

   tbChecker chk_i (.clk(clk), .arstN(arstN), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .start(start), .outValue(outValue), .outStrobe(outStrobe),
      .halted(halted), .errorCount(errorCount), .checkCount(checkCount));

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= timeoutLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
         $display("Outputs checked: %0d, errors: %0d", checkCount, errorCount);
         $display("sim failed");
         $finish;
      end
   end

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsrNext(logic [15:0] state);
      return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
   endfunction

   task automatic drawByte(output logic [7:0] value);
      int k;
      for (k = 0; k < 8; k++) begin
         lfsrState = lfsrNext(lfsrState);
         value[k] = lfsrState[0];
      end
   endtask

   // 40 random instructions without jumps, RAM reads or early halts.
   task automatic buildRandom();
      logic [7:0] raw;
      logic [7:0] imm;
      destT       dest;
      srcT        src;
      int         i;
      for (i = 0; i < 40; i++) begin
         drawByte(raw);
         dest = destT'(raw[6:4]);
         src = srcT'(raw[2:0]);
         if (dest == destPc) begin
            dest = destQ;
         end
         if (dest == destHalt) begin
            dest = destA;
         end
         if (src == srcRam) begin
            src = srcZero;
         end
         progBytes.push_back({raw[7], dest, raw[3], src});
         if (src == srcRom) begin
            drawByte(imm);
            progBytes.push_back(imm);
         end
      end
      progBytes.push_back({1'b0, destHalt, 1'b0, srcZero});
   endtask

   task automatic applyReset();
      arstN = 1'b0;
      repeat (resetCycles) @(negedge clk);
      arstN = 1'b1;
   endtask

   // Reset, load the ROM, start and wait for halt with a bound.
   task automatic runProgram();
      int i;
      int waited;
      applyReset();
      for (i = 0; i < progBytes.size(); i++) begin
         @(negedge clk);
         progWe = 1'b1;
         progAddr = romAddrWidth'(i);
         progData = progBytes[i];
      end
      @(negedge clk);
      progWe = 1'b0;
      progBytes.delete();
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      waited = 0;
      while (!halted && waited < runBudget) begin
         @(negedge clk);
         waited++;
      end
      repeat (2) @(negedge clk);
   endtask

   initial begin
      arstN = 1'b0;
      start = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      lfsrState = lfsrSeed;
      // Immediates and zero into A, B and X, copies to Q, immediate on destNone.
      progBytes = '{8'h20, 8'h5A, 8'h30, 8'hC3, 8'h40, 8'h3C, 8'h62, 8'h63, 8'h64,
                    8'h41, 8'h64, 8'h21, 8'h62, 8'h60, 8'h7E, 8'h00, 8'h99, 8'h71};
      runProgram();
      // Add, add with carry-in, subtract, then a taken and a skipped carry jump.
      progBytes = '{8'h20, 8'h37, 8'h30, 8'h15, 8'h66, 8'hE6, 8'hEE, 8'h6E, 8'h20, 8'hF0,
                    8'h30, 8'h20, 8'h26, 8'h90, 8'h12, 8'h60, 8'h11, 8'h71, 8'h60, 8'h22,
                    8'h66, 8'h90, 8'h1A, 8'h60, 8'h33, 8'h71, 8'h60, 8'h44, 8'h71};
      runProgram();
      // Countdown from 5, Q on every pass, leave on zero.
      progBytes = '{8'h20, 8'h05, 8'h30, 8'h01, 8'h62, 8'hAE, 8'h18, 8'h0A, 8'h10, 8'h04,
                    8'h71};
      runProgram();
      // Shifts with both shift-in values, one taken and one skipped shift jump.
      progBytes = '{8'h20, 8'h81, 8'h6F, 8'h27, 8'h98, 8'h08, 8'h60, 8'hEE, 8'h62, 8'h20,
                    8'h01, 8'h2F, 8'h98, 8'h10, 8'h62, 8'h71, 8'h60, 8'hBB, 8'h71};
      runProgram();
      // RAM stores at three X addresses, reads back, jump over one instruction.
      progBytes = '{8'h40, 8'h10, 8'h20, 8'hAA, 8'h52, 8'h40, 8'h11, 8'h50, 8'hBB, 8'h40,
                    8'hFF, 8'h51, 8'h40, 8'h10, 8'h65, 8'h10, 8'h13, 8'h60, 8'hEE, 8'h40,
                    8'h11, 8'h65, 8'h40, 8'hFF, 8'h65, 8'h71};
      runProgram();
      repeat (programCount - 5) begin
         buildRandom();
         runProgram();
      end
      // Final reset lets the checker close the last program.
      applyReset();
      repeat (2) @(negedge clk);
      $display("Outputs checked: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: compile.f
cpuPkg.sv
controlDecoder.sv
phaseSequencer.sv
programCounter.sv
registerFile.sv
aluShifter.sv
programMemory.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tbCpu
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
